//--- src/axi_cdc_pkg.sv
package axi_cdc_pkg;

    localparam int ID_W    = 4;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int LEN_W   = 8;   // Beats = len + 1.
    localparam int FIFO_AW = 3;   // Depth 8.
    localparam int MEM_AW  = 8;   // 256 words.

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRESP,
        READ
    } mem_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Channel beats
    ////////////////////////////////////////////////////////////////////////////

    // Shared by AW and AR.
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_e            burst;
    } addr_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } wdata_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } rdata_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } wresp_beat_t;

endpackage

//--- src/axi_bus_if.sv
interface axi_bus_if;
    import axi_cdc_pkg::*;

    addr_beat_t  aw;
    logic        aw_valid;
    logic        aw_ready;

    wdata_beat_t w;
    logic        w_valid;
    logic        w_ready;

    wresp_beat_t b;
    logic        b_valid;
    logic        b_ready;

    addr_beat_t  ar;
    logic        ar_valid;
    logic        ar_ready;

    rdata_beat_t r;
    logic        r_valid;
    logic        r_ready;

    // Bridge side.
    modport master (
        output aw, aw_valid, input aw_ready,
        output w, w_valid, input w_ready,
        input b, b_valid, output b_ready,
        output ar, ar_valid, input ar_ready,
        input r, r_valid, output r_ready
    );

    // Memory side.
    modport slave (
        input aw, aw_valid, output aw_ready,
        input w, w_valid, output w_ready,
        output b, b_valid, input b_ready,
        input ar, ar_valid, output ar_ready,
        output r, r_valid, input r_ready
    );

endinterface

//--- src/async_fifo.sv
module async_fifo #(
    parameter int WIDTH = 8,
    parameter int AW    = axi_cdc_pkg::FIFO_AW
) (
    input  logic             wr_clk,
    input  logic             wr_rstn,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             wr_full,
    input  logic             rd_clk,
    input  logic             rd_rstn,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_empty
);
    logic [WIDTH-1:0] mem [2**AW];

    logic [AW:0] wr_bin, wr_gray, wr_bin_nxt;
    logic [AW:0] rd_bin, rd_gray, rd_bin_nxt;
    logic [AW:0] rd_gray_s1, rd_gray_s2;   // Read pointer in write domain.
    logic [AW:0] wr_gray_s1, wr_gray_s2;   // Write pointer in read domain.

    ////////////////////////////////////////////////////////////////////////////
    // Write domain
    ////////////////////////////////////////////////////////////////////////////

    assign wr_bin_nxt = wr_bin + 1'b1;
    // Full when the top two Gray bits differ and the rest match.
    assign wr_full = (wr_gray == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (wr_en) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en) mem[wr_bin[AW-1:0]] <= wr_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read domain
    ////////////////////////////////////////////////////////////////////////////

    assign rd_bin_nxt = rd_bin + 1'b1;
    assign rd_empty   = (rd_gray == wr_gray_s2);

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (rd_en) begin
                rd_bin  <= rd_bin_nxt;
                rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) rd_data <= mem[rd_bin[AW-1:0]];
    end

    assert property (@(posedge wr_clk) disable iff (!wr_rstn) wr_en |-> !wr_full)
        else $error("async_fifo: write while full");
    assert property (@(posedge rd_clk) disable iff (!rd_rstn) rd_en |-> !rd_empty)
        else $error("async_fifo: read while empty");

endmodule

//--- src/cdc_channel.sv
module cdc_channel #(
    parameter int WIDTH = 8
) (
    input  logic             in_clk,
    input  logic             in_rstn,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    input  logic             out_clk,
    input  logic             out_rstn,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             empty
);
    logic wr_full;
    logic rd_en;
    logic out_hs;
    logic prefetch;   // Output stage holds no beat.

    assign in_ready  = in_rstn && !wr_full;
    assign out_valid = !prefetch;
    assign out_hs    = out_valid && out_ready;
    // Fill an empty stage, or refill behind a consumed beat.
    assign rd_en     = !empty && (prefetch || out_hs);

    always_ff @(posedge out_clk or negedge out_rstn) begin
        if (!out_rstn) begin
            prefetch <= 1'b1;
        end else if (out_hs && empty) begin
            prefetch <= 1'b1;
        end else if (rd_en) begin
            prefetch <= 1'b0;
        end
    end

    async_fifo #(.WIDTH(WIDTH)) u_fifo (
        .wr_clk   (in_clk),
        .wr_rstn  (in_rstn),
        .wr_en    (in_valid && in_ready),
        .wr_data  (in_data),
        .wr_full  (wr_full),
        .rd_clk   (out_clk),
        .rd_rstn  (out_rstn),
        .rd_en    (rd_en),
        .rd_data  (out_data),
        .rd_empty (empty)
    );

    assert property (@(posedge out_clk) disable iff (!out_rstn)
        (out_valid && !out_ready) |=> $stable(out_data))
        else $error("cdc_channel: out_data changed while stalled");

endmodule

//--- src/axi_slave_cdc.sv
module axi_slave_cdc (
    input  logic                          BUS_CLK,
    input  logic                          BUS_RSTN_SYNC,
    input  logic                          SLAVE_CLK,
    input  logic                          SLAVE_RSTN_SYNC,
    input  logic [axi_cdc_pkg::ID_W-1:0]   bus_aw_id,
    input  logic [axi_cdc_pkg::ADDR_W-1:0] bus_aw_addr,
    input  logic [axi_cdc_pkg::LEN_W-1:0]  bus_aw_len,
    input  logic [1:0]                    bus_aw_burst,
    input  logic                          bus_aw_valid,
    output logic                          bus_aw_ready,
    input  logic [axi_cdc_pkg::DATA_W-1:0] bus_w_data,
    input  logic [axi_cdc_pkg::STRB_W-1:0] bus_w_strb,
    input  logic                          bus_w_last,
    input  logic                          bus_w_valid,
    output logic                          bus_w_ready,
    output logic [axi_cdc_pkg::ID_W-1:0]   bus_b_id,
    output logic [1:0]                    bus_b_resp,
    output logic                          bus_b_valid,
    input  logic                          bus_b_ready,
    input  logic [axi_cdc_pkg::ID_W-1:0]   bus_ar_id,
    input  logic [axi_cdc_pkg::ADDR_W-1:0] bus_ar_addr,
    input  logic [axi_cdc_pkg::LEN_W-1:0]  bus_ar_len,
    input  logic [1:0]                    bus_ar_burst,
    input  logic                          bus_ar_valid,
    output logic                          bus_ar_ready,
    output logic [axi_cdc_pkg::ID_W-1:0]   bus_r_id,
    output logic [axi_cdc_pkg::DATA_W-1:0] bus_r_data,
    output logic [1:0]                    bus_r_resp,
    output logic                          bus_r_last,
    output logic                          bus_r_valid,
    input  logic                          bus_r_ready,
    axi_bus_if.master                     slv,
    output logic [4:0]                    fifo_empty_flag
);
    import axi_cdc_pkg::*;

    addr_beat_t  aw_in, ar_in;
    wdata_beat_t w_in;
    wresp_beat_t b_out;
    rdata_beat_t r_out;
    logic aw_empty, ar_empty, w_empty, r_empty, b_empty;

    assign aw_in = '{id: bus_aw_id, addr: bus_aw_addr, len: bus_aw_len,
                     burst: burst_e'(bus_aw_burst)};
    assign ar_in = '{id: bus_ar_id, addr: bus_ar_addr, len: bus_ar_len,
                     burst: burst_e'(bus_ar_burst)};
    assign w_in  = '{data: bus_w_data, strb: bus_w_strb, last: bus_w_last};

    assign bus_b_id   = b_out.id;
    assign bus_b_resp = b_out.resp;
    assign bus_r_id   = r_out.id;
    assign bus_r_data = r_out.data;
    assign bus_r_resp = r_out.resp;
    assign bus_r_last = r_out.last;

    ////////////////////////////////////////////////////////////////////////////
    // BUS_CLK to SLAVE_CLK
    ////////////////////////////////////////////////////////////////////////////

    cdc_channel #(.WIDTH($bits(addr_beat_t))) u_aw (
        .in_clk(BUS_CLK), .in_rstn(BUS_RSTN_SYNC),
        .in_valid(bus_aw_valid), .in_ready(bus_aw_ready), .in_data(aw_in),
        .out_clk(SLAVE_CLK), .out_rstn(SLAVE_RSTN_SYNC),
        .out_valid(slv.aw_valid), .out_ready(slv.aw_ready), .out_data(slv.aw),
        .empty(aw_empty)
    );

    cdc_channel #(.WIDTH($bits(addr_beat_t))) u_ar (
        .in_clk(BUS_CLK), .in_rstn(BUS_RSTN_SYNC),
        .in_valid(bus_ar_valid), .in_ready(bus_ar_ready), .in_data(ar_in),
        .out_clk(SLAVE_CLK), .out_rstn(SLAVE_RSTN_SYNC),
        .out_valid(slv.ar_valid), .out_ready(slv.ar_ready), .out_data(slv.ar),
        .empty(ar_empty)
    );

    cdc_channel #(.WIDTH($bits(wdata_beat_t))) u_w (
        .in_clk(BUS_CLK), .in_rstn(BUS_RSTN_SYNC),
        .in_valid(bus_w_valid), .in_ready(bus_w_ready), .in_data(w_in),
        .out_clk(SLAVE_CLK), .out_rstn(SLAVE_RSTN_SYNC),
        .out_valid(slv.w_valid), .out_ready(slv.w_ready), .out_data(slv.w),
        .empty(w_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // SLAVE_CLK to BUS_CLK
    ////////////////////////////////////////////////////////////////////////////

    cdc_channel #(.WIDTH($bits(rdata_beat_t))) u_r (
        .in_clk(SLAVE_CLK), .in_rstn(SLAVE_RSTN_SYNC),
        .in_valid(slv.r_valid), .in_ready(slv.r_ready), .in_data(slv.r),
        .out_clk(BUS_CLK), .out_rstn(BUS_RSTN_SYNC),
        .out_valid(bus_r_valid), .out_ready(bus_r_ready), .out_data(r_out),
        .empty(r_empty)
    );

    cdc_channel #(.WIDTH($bits(wresp_beat_t))) u_b (
        .in_clk(SLAVE_CLK), .in_rstn(SLAVE_RSTN_SYNC),
        .in_valid(slv.b_valid), .in_ready(slv.b_ready), .in_data(slv.b),
        .out_clk(BUS_CLK), .out_rstn(BUS_RSTN_SYNC),
        .out_valid(bus_b_valid), .out_ready(bus_b_ready), .out_data(b_out),
        .empty(b_empty)
    );

    assign fifo_empty_flag = {aw_empty, ar_empty, w_empty, r_empty, b_empty};

endmodule

//--- src/axi_mem_slave.sv
module axi_mem_slave (
    input  logic      SLAVE_CLK,
    input  logic      SLAVE_RSTN_SYNC,
    axi_bus_if.slave  bus
);
    import axi_cdc_pkg::*;

    mem_state_e        state;
    logic [DATA_W-1:0] mem [2**MEM_AW];
    logic [MEM_AW-1:0] idx;        // Word of the current beat.
    logic [MEM_AW-1:0] idx_nxt;
    logic [LEN_W-1:0]  beat_cnt;
    logic [LEN_W-1:0]  len_q;
    logic [ID_W-1:0]   id_q;
    burst_e            burst_q;
    logic [DATA_W-1:0] rdata_q;
    logic aw_hs, ar_hs, w_hs, b_hs, r_hs;
    logic last_beat;
    logic err;

    // Writes win when both address channels are valid.
    assign bus.aw_ready = (state == IDLE);
    assign bus.ar_ready = (state == IDLE) && !bus.aw_valid;
    assign bus.w_ready  = (state == WRITE);
    assign bus.b_valid  = (state == WRESP);
    assign bus.r_valid  = (state == READ);

    assign aw_hs = bus.aw_valid && bus.aw_ready;
    assign ar_hs = bus.ar_valid && bus.ar_ready;
    assign w_hs  = bus.w_valid && bus.w_ready;
    assign b_hs  = bus.b_valid && bus.b_ready;
    assign r_hs  = bus.r_valid && bus.r_ready;

    assign last_beat = (beat_cnt == len_q);
    assign err       = (burst_q == WRAP);
    assign idx_nxt   = (burst_q == INCR) ? idx + 1'b1 : idx;   // FIXED stays put.

    assign bus.b = '{id: id_q, resp: err ? SLVERR : OKAY};
    assign bus.r = '{id: id_q, data: rdata_q, resp: err ? SLVERR : OKAY, last: last_beat};

    ////////////////////////////////////////////////////////////////////////////
    // Burst FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge SLAVE_CLK or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    beat_cnt <= '0;
                    if (aw_hs) state <= WRITE;
                    else if (ar_hs) state <= READ;
                end
                WRITE: begin
                    if (w_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) state <= WRESP;
                    end
                end
                WRESP: begin
                    if (b_hs) state <= IDLE;
                end
                READ: begin
                    if (r_hs) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Transaction fields and read data.
    always_ff @(posedge SLAVE_CLK) begin
        if (aw_hs) begin
            id_q    <= bus.aw.id;
            len_q   <= bus.aw.len;
            burst_q <= bus.aw.burst;
            idx     <= bus.aw.addr[MEM_AW+1:2];
        end else if (ar_hs) begin
            id_q    <= bus.ar.id;
            len_q   <= bus.ar.len;
            burst_q <= bus.ar.burst;
            idx     <= bus.ar.addr[MEM_AW+1:2];
            rdata_q <= (bus.ar.burst == WRAP) ? '0 : mem[bus.ar.addr[MEM_AW+1:2]];
        end
        if (w_hs) idx <= idx_nxt;
        if (r_hs && !last_beat) begin
            idx     <= idx_nxt;
            rdata_q <= err ? '0 : mem[idx_nxt];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory array
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge SLAVE_CLK or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            for (int i = 0; i < 2**MEM_AW; i++) begin
                mem[i] <= '0;
            end
        end else if (w_hs && !err) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (bus.w.strb[b]) mem[idx][8*b +: 8] <= bus.w.data[8*b +: 8];   // Byte merge.
            end
        end
    end

    // Master's last flag agrees with the AW length.
    assert property (@(posedge SLAVE_CLK) disable iff (!SLAVE_RSTN_SYNC)
        w_hs |-> (bus.w.last == last_beat))
        else $error("axi_mem_slave: w last does not match burst length");

endmodule

//--- src/axi_cdc_top.sv
module axi_cdc_top (
    input  logic                          BUS_CLK,
    input  logic                          BUS_RSTN_SYNC,
    input  logic                          SLAVE_CLK,
    input  logic                          SLAVE_RSTN_SYNC,
    input  logic [axi_cdc_pkg::ID_W-1:0]   bus_aw_id,
    input  logic [axi_cdc_pkg::ADDR_W-1:0] bus_aw_addr,
    input  logic [axi_cdc_pkg::LEN_W-1:0]  bus_aw_len,
    input  logic [1:0]                    bus_aw_burst,
    input  logic                          bus_aw_valid,
    output logic                          bus_aw_ready,
    input  logic [axi_cdc_pkg::DATA_W-1:0] bus_w_data,
    input  logic [axi_cdc_pkg::STRB_W-1:0] bus_w_strb,
    input  logic                          bus_w_last,
    input  logic                          bus_w_valid,
    output logic                          bus_w_ready,
    output logic [axi_cdc_pkg::ID_W-1:0]   bus_b_id,
    output logic [1:0]                    bus_b_resp,
    output logic                          bus_b_valid,
    input  logic                          bus_b_ready,
    input  logic [axi_cdc_pkg::ID_W-1:0]   bus_ar_id,
    input  logic [axi_cdc_pkg::ADDR_W-1:0] bus_ar_addr,
    input  logic [axi_cdc_pkg::LEN_W-1:0]  bus_ar_len,
    input  logic [1:0]                    bus_ar_burst,
    input  logic                          bus_ar_valid,
    output logic                          bus_ar_ready,
    output logic [axi_cdc_pkg::ID_W-1:0]   bus_r_id,
    output logic [axi_cdc_pkg::DATA_W-1:0] bus_r_data,
    output logic [1:0]                    bus_r_resp,
    output logic                          bus_r_last,
    output logic                          bus_r_valid,
    input  logic                          bus_r_ready,
    output logic [4:0]                    fifo_empty_flag
);

    axi_bus_if slv_bus ();

    // Bus ports share names with the top.
    axi_slave_cdc u_axi_slave_cdc (
        .*,
        .slv (slv_bus.master)
    );

    axi_mem_slave u_axi_mem_slave (
        .SLAVE_CLK       (SLAVE_CLK),
        .SLAVE_RSTN_SYNC (SLAVE_RSTN_SYNC),
        .bus             (slv_bus.slave)
    );

endmodule

//--- tb/tb_axi_cdc.sv
module tb_axi_cdc;
    timeunit 1ns;
    timeprecision 100ps;
    import axi_cdc_pkg::*;

    localparam int BUS_HALF  = 7;   // 14 ns BUS_CLK.
    localparam int MAX_OPS   = 32;
    localparam int MAX_BEATS = 16;
    localparam int MAX_TESTS = 8;
    localparam logic [31:0] SEED = 32'hc5d3_80e9;

    logic slave_clk = 1'b0;
    logic bus_clk   = 1'b0;
    logic slave_rstn, bus_rstn;

    logic [ID_W-1:0]   bus_aw_id, bus_ar_id, bus_b_id, bus_r_id;
    logic [ADDR_W-1:0] bus_aw_addr, bus_ar_addr;
    logic [LEN_W-1:0]  bus_aw_len, bus_ar_len;
    logic [1:0]        bus_aw_burst, bus_ar_burst, bus_b_resp, bus_r_resp;
    logic [DATA_W-1:0] bus_w_data, bus_r_data;
    logic [STRB_W-1:0] bus_w_strb;
    logic bus_aw_valid, bus_aw_ready, bus_ar_valid, bus_ar_ready;
    logic bus_w_last, bus_w_valid, bus_w_ready;
    logic bus_b_valid, bus_r_valid, bus_r_last;
    logic bus_b_ready = 1'b0;
    logic bus_r_ready = 1'b0;
    logic [4:0] fifo_empty_flag;

    // Operations as read from the data file.
    logic              op_wr    [MAX_OPS];
    logic [ID_W-1:0]   op_id    [MAX_OPS];
    logic [ADDR_W-1:0] op_addr  [MAX_OPS];
    logic [LEN_W-1:0]  op_len   [MAX_OPS];
    logic [1:0]        op_burst [MAX_OPS];
    logic [1:0]        op_resp  [MAX_OPS];
    logic [DATA_W-1:0] op_data  [MAX_OPS][MAX_BEATS];
    logic [STRB_W-1:0] op_strb  [MAX_OPS][MAX_BEATS];
    string test_name  [MAX_TESTS];
    logic  test_bp    [MAX_TESTS];
    int    test_first [MAX_TESTS+1];

    int n_ops     = 0;
    int n_tests   = 0;
    int max_beats = 1;
    int limit     = 0;
    int cycles    = 0;
    int checks    = 0;
    int errors    = 0;
    int r_beat    = 0;
    int b_pending[$];   // Writes waiting for B.
    int r_pending[$];
    logic back_pressure = 1'b0;
    logic seeded        = 1'b0;

    always #10 slave_clk = ~slave_clk;
    always #(BUS_HALF) bus_clk = ~bus_clk;

    axi_cdc_top u_axi_cdc_top (
        .BUS_CLK         (bus_clk),
        .BUS_RSTN_SYNC   (bus_rstn),
        .SLAVE_CLK       (slave_clk),
        .SLAVE_RSTN_SYNC (slave_rstn),
        .*
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic void split_words(input string line, output string words[$]);
        string cur;
        words = {};
        cur   = "";
        for (int k = 0; k < line.len(); k++) begin
            if (line[k] == " " || line[k] == "\t" || line[k] == "\n" || line[k] == "\r") begin
                if (cur.len() > 0) words.push_back(cur);
                cur = "";
            end else begin
                cur = {cur, line.substr(k, k)};
            end
        end
        if (cur.len() > 0) words.push_back(cur);
    endfunction

    function automatic bit load_ops();
        int    fd;
        int    nb;
        string line;
        string w[$];
        fd = $fopen("tb/cdc_input.txt", "r");
        if (fd == 0) return 1'b0;
        while ($fgets(line, fd) != 0) begin
            split_words(line, w);
            if (w.size() == 0 || w[0].substr(0, 0) == "#") continue;
            if (w[0] == "T") begin
                test_name[n_tests]  = w[1];
                test_bp[n_tests]    = (w[2].atoi() != 0);
                test_first[n_tests] = n_ops;
                n_tests++;
            end else begin
                op_wr[n_ops]    = (w[0] == "W");
                op_id[n_ops]    = ID_W'(w[1].atohex());
                op_addr[n_ops]  = ADDR_W'(w[2].atohex());
                op_len[n_ops]   = LEN_W'(w[3].atohex());
                op_burst[n_ops] = 2'(w[4].atohex());
                op_resp[n_ops]  = 2'(w[5].atohex());
                nb = int'(op_len[n_ops]) + 1;
                if (nb > max_beats) max_beats = nb;
                for (int k = 0; k < nb; k++) begin
                    if (op_wr[n_ops]) begin
                        op_data[n_ops][k] = DATA_W'(w[6 + 2*k].atohex());
                        op_strb[n_ops][k] = STRB_W'(w[7 + 2*k].atohex());
                    end else begin
                        op_data[n_ops][k] = DATA_W'(w[6 + k].atohex());
                    end
                end
                n_ops++;
            end
        end
        test_first[n_tests] = n_ops;
        $fclose(fd);
        return 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus-side drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue_write(input int i);
        b_pending.push_back(i);
        @(posedge bus_clk);
        bus_aw_id    <= op_id[i];
        bus_aw_addr  <= op_addr[i];
        bus_aw_len   <= op_len[i];
        bus_aw_burst <= op_burst[i];
        bus_aw_valid <= 1'b1;
        do @(posedge bus_clk); while (!bus_aw_ready);
        bus_aw_valid <= 1'b0;
        for (int k = 0; k <= int'(op_len[i]); k++) begin
            bus_w_data  <= op_data[i][k];
            bus_w_strb  <= op_strb[i][k];
            bus_w_last  <= (k == int'(op_len[i]));
            bus_w_valid <= 1'b1;
            do @(posedge bus_clk); while (!bus_w_ready);
        end
        bus_w_valid <= 1'b0;
    endtask

    task automatic issue_read(input int i);
        r_pending.push_back(i);
        @(posedge bus_clk);
        bus_ar_id    <= op_id[i];
        bus_ar_addr  <= op_addr[i];
        bus_ar_len   <= op_len[i];
        bus_ar_burst <= op_burst[i];
        bus_ar_valid <= 1'b1;
        do @(posedge bus_clk); while (!bus_ar_ready);
        bus_ar_valid <= 1'b0;
    endtask

    task automatic wait_fifos_empty();
        int n;
        n = 0;
        while (fifo_empty_flag != 5'h1f && n < 16) begin
            @(posedge bus_clk);
            n++;
        end
        check_value("fifo_empty_flag", 32'h1f, 32'(fifo_empty_flag));
    endtask

    task automatic run_test(input int t);
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        back_pressure = test_bp[t];
        for (int i = test_first[t]; i < test_first[t+1]; i++) begin
            if (op_wr[i]) begin
                issue_write(i);   // Writes may queue up.
            end else begin
                while (b_pending.size() != 0) @(posedge bus_clk);
                issue_read(i);
                while (r_pending.size() != 0) @(posedge bus_clk);
            end
        end
        while (b_pending.size() != 0 || r_pending.size() != 0) @(posedge bus_clk);
        back_pressure = 1'b0;
        wait_fifos_empty();
        $display("Test %0s: %0d checks, %0d errors", test_name[t], checks - c0, errors - e0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Ready generation and response checking
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge bus_clk) begin
        logic [31:0] rnd;
        if (!seeded) begin
            void'($urandom(SEED));
            seeded = 1'b1;
        end
        rnd = $urandom();
        bus_b_ready <= back_pressure ? rnd[0] : 1'b1;
        bus_r_ready <= back_pressure ? rnd[1] : 1'b1;
    end

    always @(posedge bus_clk) begin
        int i;
        if (bus_b_valid && bus_b_ready) begin
            assert (b_pending.size() != 0) else begin
                $display("Write response at %0t ns with no write outstanding", $time);
                errors++;
            end
            if (b_pending.size() != 0) begin
                i = b_pending.pop_front();
                check_value("bus_b_id", 32'(op_id[i]), 32'(bus_b_id));
                check_value("bus_b_resp", 32'(op_resp[i]), 32'(bus_b_resp));
            end
        end
        if (bus_r_valid && bus_r_ready) begin
            assert (r_pending.size() != 0) else begin
                $display("Read beat at %0t ns with no read outstanding", $time);
                errors++;
            end
            if (r_pending.size() != 0) begin
                i = r_pending[0];
                check_value("bus_r_id", 32'(op_id[i]), 32'(bus_r_id));
                check_value("bus_r_data", op_data[i][r_beat], bus_r_data);
                check_value("bus_r_resp", 32'(op_resp[i]), 32'(bus_r_resp));
                check_value("bus_r_last", 32'(r_beat == int'(op_len[i])), 32'(bus_r_last));
                if (r_beat == int'(op_len[i])) begin
                    void'(r_pending.pop_front());
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
        end
    end

    always @(posedge slave_clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d SLAVE_CLK cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        slave_rstn   = 1'b0;
        bus_rstn     = 1'b0;
        bus_aw_id    = '0;
        bus_aw_addr  = '0;
        bus_aw_len   = '0;
        bus_aw_burst = '0;
        bus_aw_valid = 1'b0;
        bus_w_data   = '0;
        bus_w_strb   = '0;
        bus_w_last   = 1'b0;
        bus_w_valid  = 1'b0;
        bus_ar_id    = '0;
        bus_ar_addr  = '0;
        bus_ar_len   = '0;
        bus_ar_burst = '0;
        bus_ar_valid = 1'b0;
        if (!load_ops()) begin
            $display("Cannot open the stimulus file tb/cdc_input.txt");
            $display("Errors found");
            $finish;
        end else begin
            limit = n_ops * (4 * max_beats + 64);
            repeat (4) @(posedge slave_clk);
            slave_rstn <= 1'b1;
            bus_rstn   <= 1'b1;
            @(posedge bus_clk);
            check_value("bus_b_valid", 32'h0, 32'(bus_b_valid));
            check_value("bus_r_valid", 32'h0, 32'(bus_r_valid));
            check_value("fifo_empty_flag", 32'h1f, 32'(fifo_empty_flag));
            $display("Test reset_state: %0d checks, %0d errors", checks, errors);
            for (int t = 0; t < n_tests; t++) begin
                run_test(t);
            end
            $display("Summary: %0d tests, %0d checks, %0d errors", n_tests + 1, checks, errors);
            if (errors == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

//--- tb/cdc_input.txt
# T name back_pressure | W id addr len burst resp, then data strb per beat
# R id addr len burst resp, then expected data per beat (hex, burst 0 FIXED 1 INCR 2 WRAP)
T single_rw 0
W 1 00000010 0 1 0 deadbeef f
R 1 00000010 0 1 0 deadbeef
T incr_strobes 0
W 2 00000040 3 1 0 11223344 f 55667788 3 99aabbcc c a1b2c3d4 5
R 2 00000040 3 1 0 11223344 00007788 99aa0000 00b200d4
T fixed_burst 0
W 3 00000080 2 0 0 000000aa 1 0000bb00 2 12345678 8
R 3 00000080 2 0 0 1200bbaa 1200bbaa 1200bbaa
T wrap_reject 0
W 4 00000010 1 2 2 ffffffff f 00000000 f
R 4 00000010 0 1 0 deadbeef
R 5 00000040 3 2 2 00000000 00000000 00000000 00000000
T back_pressure 1
W 6 00000100 3 1 0 01010101 f 02020202 f 03030303 f 04040404 f
W 7 00000110 3 1 0 05050505 f 06060606 f 07070707 f 08080808 f
W 8 00000120 0 1 0 cafef00d 3
R 9 00000100 7 1 0 01010101 02020202 03030303 04040404 05050505 06060606 07070707 08080808
R a 00000120 0 1 0 0000f00d

//--- project.f
src/axi_cdc_pkg.sv
src/axi_bus_if.sv
src/async_fifo.sv
src/cdc_channel.sv
src/axi_slave_cdc.sv
src/axi_mem_slave.sv
src/axi_cdc_top.sv
tb/tb_axi_cdc.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_axi_cdc -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
